// ==== files.f ====
verilog/acq_pkg.sv
verilog/link_pkg.sv
verilog/acq_sequencer.sv
verilog/mux_handshake.sv
verilog/link_interface.sv
verilog/tx_buffer.sv
verilog/serial_tx.sv
verilog/data_logger_top.sv
testbench/data_logger_assertions.sv
testbench/tb_data_logger.sv

// ==== testbench/data_logger_assertions.sv ====
// serial link protocol checks
// load and send strobes never overlap; on the buffer side a
// running frame never coexists with error and tx_end only
// arrives while send_en is still held
`timescale 1ns/1ps
`default_nettype none

module data_logger_assertions #(
	parameter bit TX_CHECKS = 1'b1
) (
	input logic                clock,
	input logic                rst,
	input link_pkg::link_ctl_t ctl,
	input logic                send_en,
	input logic                error,
	input logic                tx_end
);
	load_send_apart: assert property (@(posedge clock) disable iff (rst)
		!(ctl.load && ctl.send))
		else $error("load and send strobes high in the same cycle");

	// buffer side only, the link interface has no send_en or error
	generate
		if (TX_CHECKS) begin : g_tx
			no_frame_on_error: assert property (@(posedge clock) disable iff (rst)
				send_en |-> !error)
				else $error("send_en high while error is set");
			end_inside_frame: assert property (@(posedge clock) disable iff (rst)
				tx_end |-> send_en)
				else $error("tx_end without send_en");
		end
	endgenerate

endmodule

`default_nettype wire

// ==== testbench/tb_data_logger.sv ====
// data logger testbench
// table of conversions applied in a loop, with a converter model
// answering soc, a serial decoder on data_out and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_data_logger;
	import acq_pkg::*;

	localparam int BIT_PERIOD = 8;
	localparam int NUM_ROWS = 9;

	// eoc busy cycles, byte, dsr level and expected error of one conversion
	typedef struct packed {
		logic [7:0] busy;
		logic [7:0] data;
		logic       dsr;
		logic       err;
	} row_t;

	row_t rows [NUM_ROWS] = '{
		'{8'd2, 8'hA5, 1'b1, 1'b0},
		'{8'd5, 8'h3C, 1'b1, 1'b0},
		'{8'd1, 8'h81, 1'b0, 1'b1},
		'{8'd3, 8'h5A, 1'b1, 1'b0},
		'{8'd9, 8'hFF, 1'b1, 1'b0},
		'{8'd4, 8'h00, 1'b0, 1'b1},
		'{8'd2, 8'h7E, 1'b1, 1'b0},
		'{8'd6, 8'hC3, 1'b1, 1'b0},
		'{8'd1, 8'h96, 1'b1, 1'b0}
	};

	logic clock = 1'b0;
	logic rst;
	logic eoc;
	logic [7:0] data_in;
	logic dsr;
	logic soc;
	logic load_dato;
	logic add_mpx2;
	channel_t canale;
	logic mux_en;
	logic error;
	logic data_out;

	int cur_delay;
	int checks;
	int errors;
	int load_count;
	logic [31:0] seed;
	logic [7:0] frame_bytes[$];
	logic frame_mpx[$];

	data_logger_top #(.BIT_PERIOD(BIT_PERIOD)) dut0 (
		.clock(clock), .rst(rst), .eoc(eoc), .data_in(data_in), .dsr(dsr),
		.soc(soc), .load_dato(load_dato), .add_mpx2(add_mpx2), .canale(canale),
		.mux_en(mux_en), .error(error), .data_out(data_out)
	);

	bind tx_buffer data_logger_assertions #(.TX_CHECKS(1'b1)) buf_checks (
		.clock(clock), .rst(rst), .ctl(ctl), .send_en(send_en),
		.error(error), .tx_end(tx_end)
	);
	bind link_interface data_logger_assertions #(.TX_CHECKS(1'b0)) itfc_checks (
		.clock(clock), .rst(rst), .ctl(ctl), .send_en(1'b0),
		.error(1'b0), .tx_end(tx_end)
	);

	always #20 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
		end
	endtask

	// drive one row on a falling edge
	// eoc delay gets 0..3 random extra cycles
	task automatic apply_row(input int r);
		seed = lcg_next(seed);
		data_in = rows[r].data;
		dsr = rows[r].dsr;
		cur_delay = int'(rows[r].busy) + int'(seed[17:16]);
	endtask

	// converter model holds eoc high for cur_delay cycles after soc
	initial begin : converter_model
		eoc = 1'b0;
		forever begin
			@(negedge clock);
			if (soc && !rst) begin
				eoc = 1'b1;
				repeat (cur_delay) @(negedge clock);
				eoc = 1'b0;
				while (soc) @(negedge clock);
			end
		end
	end

	always @(negedge clock) begin
		if (load_dato) load_count++;
	end

	// decoder samples mid-bit and msb first
	// add_mpx2 taken at the start bit
	initial begin : serial_decoder
		logic [7:0] shift;
		logic mpx;
		@(negedge rst);
		forever begin
			@(negedge data_out);
			repeat (BIT_PERIOD / 2) @(negedge clock);
			check("start_bit", data_out, 1'b0);
			mpx = add_mpx2;
			for (int k = 0; k < 8; k++) begin
				repeat (BIT_PERIOD) @(negedge clock);
				shift = {shift[6:0], data_out};
			end
			repeat (BIT_PERIOD) @(negedge clock);
			check("stop_bit", data_out, 1'b1);
			frame_bytes.push_back(shift);
			frame_mpx.push_back(mpx);
		end
	end

	// limit from two frames, the eoc delay and some slack per row
	initial begin : watchdog
		int limit;
		limit = 4;
		foreach (rows[r]) limit += 2 * 10 * BIT_PERIOD + int'(rows[r].busy) + 3 + 40;
		repeat (limit) @(posedge clock);
		$display("timeout after %0d cycles, a conversion did not finish", limit);
		$display("test failed");
		$finish;
	end

	initial begin : stimulus
		channel_t exp_ch;
		int n_exp;
		int row_start;
		rst = 1'b1;
		seed = 32'd3;
		checks = 0;
		errors = 0;
		load_count = 0;
		exp_ch = '0;
		apply_row(0);
		repeat (4) @(negedge clock);
		// outputs while still in reset
		check("soc", soc, 1'b0);
		check("load_dato", load_dato, 1'b0);
		check("add_mpx2", add_mpx2, 1'b0);
		check("error", error, 1'b0);
		check("mux_en", mux_en, 1'b0);
		check("data_out", data_out, 1'b1);
		rst = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			row_start = errors;
			load_count = 0;
			while (!soc) @(negedge clock);
			// mux_en comes up two cycles before soc
			check("mux_en", mux_en, 1'b1);
			// conversion ends when send_data falls
			while (!dut0.u_seq.send_data) @(negedge clock);
			while (dut0.u_seq.send_data) @(negedge clock);
			exp_ch = (exp_ch == 4'd7) ? 4'd0 : exp_ch + 4'd1;
			n_exp = rows[i].dsr ? 2 : 0;
			check("canale", canale, exp_ch);
			check("load_dato", load_count, 1);
			check("error", error, rows[i].err);
			check("frame_count", frame_bytes.size(), n_exp);
			for (int j = 0; j < frame_bytes.size() && j < n_exp; j++) begin
				check("data_out", frame_bytes[j], rows[i].data);
				check("add_mpx2", frame_mpx[j], j);
			end
			$display("row %0d channel %0h frames %0d error %0b %s", i, canale,
				frame_bytes.size(), error, (errors == row_start) ? "ok" : "bad");
			frame_bytes.delete();
			frame_mpx.delete();
			if (i + 1 < NUM_ROWS) apply_row(i + 1);
		end
		// sequencer still starts another conversion
		while (!soc) @(negedge clock);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/acq_pkg.sv ====
// acquisition package
// state encodings for the conversion sequencer and the
// multiplexer handshake, plus the channel number type
`default_nettype none

package acq_pkg;

	// conversion sequencer, one pass per converted sample
	typedef enum logic [2:0] {
		mux_on,
		settle,
		start_conv,
		wait_eoc,
		latch,
		request,
		hold,
		wait_rdy
	} seq_state_t;

	// two-shot transfer handshake towards the serial link
	typedef enum logic [1:0] {
		idle,
		fire,
		wait_confirm,
		done
	} mux_state_t;

	// channel counter runs 1..7 then wraps to 0
	typedef logic [3:0] channel_t;
	localparam channel_t last_channel = 4'd7;

endpackage

`default_nettype wire

// ==== verilog/acq_sequencer.sv ====
// acquisition sequencer
// enables the input multiplexer, starts a conversion, waits for
// end of conversion, latches the sample and steps the channel,
// then holds send_data until both transfers have completed
`timescale 1ns/1ps
`default_nettype none

module acq_sequencer (
	input  logic              clock,
	input  logic              rst,
	input  logic              eoc,
	input  logic              rdy,
	output logic              mux_en,
	output logic              soc,
	output logic              load_dato,
	output logic              send_data,
	output acq_pkg::channel_t canale
);
	import acq_pkg::*;

	seq_state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= mux_on;
			mux_en    <= 1'b0;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			send_data <= 1'b0;
			canale    <= '0;
		end else begin
			case (state)
				mux_on: begin
					mux_en <= 1'b1;
					state  <= settle;
				end
				// one idle cycle for the mux to settle
				settle: begin
					state <= start_conv;
				end
				start_conv: begin
					soc   <= 1'b1;
					state <= wait_eoc;
				end
				// converter busy while eoc is high
				wait_eoc: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= latch;
					end
				end
				latch: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					// 1..7 then back to 0
					if (canale == last_channel) begin
						canale <= '0;
					end else begin
						canale <= canale + 4'd1;
					end
					state <= request;
				end
				request: begin
					send_data <= 1'b1;
					state     <= hold;
				end
				// wait for the handshake to accept
				hold: begin
					if (rdy) begin
						state <= wait_rdy;
					end
				end
				// rdy low again means both halves went out
				wait_rdy: begin
					if (!rdy) begin
						send_data <= 1'b0;
						state     <= mux_on;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/data_logger_top.sv ====
// data logger top level
// acquisition sequencer and mux handshake feed the serial link
// interface, holding buffer and bit-timed transmitter
`timescale 1ns/1ps
`default_nettype none

module data_logger_top #(
	parameter int BIT_PERIOD = 104
) (
	input  logic              clock,
	input  logic              rst,
	input  logic              eoc,
	input  logic [7:0]        data_in,
	input  logic              dsr,
	output logic              soc,
	output logic              load_dato,
	output logic              add_mpx2,
	output acq_pkg::channel_t canale,
	output logic              mux_en,
	output logic              error,
	output logic              data_out
);
	import link_pkg::*;

	logic       send_data;
	logic       rdy;
	logic       shot;
	link_ctl_t  ctl;
	logic       send_ok;
	logic       send_en;
	logic       tx_end;
	logic [7:0] tx_byte;

	acq_sequencer u_seq (
		.clock(clock), .rst(rst), .eoc(eoc), .rdy(rdy), .mux_en(mux_en),
		.soc(soc), .load_dato(load_dato), .send_data(send_data), .canale(canale)
	);

	mux_handshake u_mux (
		.clock(clock), .rst(rst), .send_data(send_data), .confirm(ctl.confirm),
		.rdy(rdy), .shot(shot), .add_mpx2(add_mpx2)
	);

	link_interface u_itfc (
		.clock(clock), .rst(rst), .shot(shot), .tx_end(tx_end),
		.send_ok(send_ok), .ctl(ctl)
	);

	tx_buffer u_buf (
		.clock(clock), .rst(rst), .ctl(ctl), .data_in(data_in), .dsr(dsr),
		.tx_end(tx_end), .tx_byte(tx_byte), .send_en(send_en),
		.send_ok(send_ok), .error(error)
	);

	serial_tx #(.BIT_PERIOD(BIT_PERIOD)) u_tx (
		.clock(clock), .rst(rst), .send_en(send_en), .tx_byte(tx_byte),
		.data_out(data_out), .tx_end(tx_end)
	);

endmodule

`default_nettype wire

// ==== verilog/link_interface.sv ====
// serial link interface
// turns each shot into a load strobe followed by a send strobe,
// then confirms when the frame ends or the send was refused
`timescale 1ns/1ps
`default_nettype none

module link_interface (
	input  logic                clock,
	input  logic                rst,
	input  logic                shot,
	input  logic                tx_end,
	input  logic                send_ok,
	output link_pkg::link_ctl_t ctl
);
	import link_pkg::*;

	itfc_state_t state;
	// send_ok is valid in the first wait_end cycle only
	logic result_due;

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= idle;
			ctl        <= '0;
			result_due <= 1'b0;
		end else begin
			// all strobes default low
			ctl        <= '0;
			result_due <= 1'b0;
			case (state)
				idle: begin
					if (shot) begin
						ctl.load <= 1'b1;
						state    <= load;
					end
				end
				load: begin
					ctl.send <= 1'b1;
					state    <= send;
				end
				send: begin
					result_due <= 1'b1;
					state      <= wait_end;
				end
				// refused send confirms at once so the handshake moves on
				wait_end: begin
					if (tx_end || (result_due && !send_ok)) begin
						ctl.confirm <= 1'b1;
						state       <= idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/link_pkg.sv ====
// serial link package
// link interface states, frame bit positions and the
// load/send/confirm strobe bundle shared by the link blocks
`default_nettype none

package link_pkg;

	// request sequencing for one byte on the link
	typedef enum logic [1:0] {
		idle,
		load,
		send,
		wait_end
	} itfc_state_t;

	// position inside a frame
	// data positions are consecutive so the next one is pos + 1
	typedef enum logic [3:0] {
		start_bit = 4'd0,
		bit0      = 4'd1,
		bit1      = 4'd2,
		bit2      = 4'd3,
		bit3      = 4'd4,
		bit4      = 4'd5,
		bit5      = 4'd6,
		bit6      = 4'd7,
		bit7      = 4'd8,
		stop_bit  = 4'd9
	} bit_pos_t;

	// single-cycle strobes from the link interface
	typedef struct packed {
		logic load;
		logic send;
		logic confirm;
	} link_ctl_t;

endpackage

`default_nettype wire

// ==== verilog/mux_handshake.sv ====
// multiplexer transfer handshake
// accepts a send request, raises rdy and fires two shots at the
// link, one per multiplexer half; add_mpx2 marks the second half
`timescale 1ns/1ps
`default_nettype none

module mux_handshake (
	input  logic clock,
	input  logic rst,
	input  logic send_data,
	input  logic confirm,
	output logic rdy,
	output logic shot,
	output logic add_mpx2
);
	import acq_pkg::*;

	mux_state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= idle;
			rdy      <= 1'b0;
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
		end else begin
			// shot only lives for one cycle
			shot <= 1'b0;
			case (state)
				idle: begin
					if (send_data) begin
						rdy   <= 1'b1;
						state <= fire;
					end
				end
				fire: begin
					shot  <= 1'b1;
					state <= wait_confirm;
				end
				wait_confirm: begin
					if (confirm) begin
						if (!add_mpx2) begin
							// first half done, switch to second half
							add_mpx2 <= 1'b1;
							state    <= fire;
						end else begin
							add_mpx2 <= 1'b0;
							rdy      <= 1'b0;
							state    <= done;
						end
					end
				end
				// gap cycle so send_data can drop before re-arming
				done: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/serial_tx.sv ====
// serial frame transmitter
// sends a low start bit, eight data bits msb first and a high
// stop bit, each held for BIT_PERIOD clocks; tx_end pulses on
// the last cycle of the stop bit; line idles high
`timescale 1ns/1ps
`default_nettype none

module serial_tx #(
	parameter int BIT_PERIOD = 104
) (
	input  logic       clock,
	input  logic       rst,
	input  logic       send_en,
	input  logic [7:0] tx_byte,
	output logic       data_out,
	output logic       tx_end
);
	import link_pkg::*;

	localparam int CNT_W = $clog2(BIT_PERIOD);

	bit_pos_t         pos;
	logic [CNT_W-1:0] cnt;
	logic             busy;

	always_ff @(posedge clock) begin
		if (rst) begin
			pos      <= start_bit;
			cnt      <= '0;
			busy     <= 1'b0;
			data_out <= 1'b1;
			tx_end   <= 1'b0;
		end else begin
			tx_end <= 1'b0;
			if (!busy) begin
				// start bit goes out the cycle after send_en rises
				if (send_en) begin
					busy     <= 1'b1;
					pos      <= start_bit;
					cnt      <= '0;
					data_out <= 1'b0;
				end
			end else if (cnt == CNT_W'(BIT_PERIOD - 1)) begin
				cnt <= '0;
				case (pos)
					start_bit, bit0, bit1, bit2, bit3, bit4, bit5, bit6: begin
						// entering bit k sends tx_byte[7-k]
						pos      <= bit_pos_t'(pos + 4'd1);
						data_out <= tx_byte[3'd7 - pos[2:0]];
					end
					bit7: begin
						pos      <= stop_bit;
						data_out <= 1'b1;
					end
					default: begin
						busy     <= 1'b0;
						pos      <= start_bit;
						data_out <= 1'b1;
					end
				endcase
			end else begin
				cnt <= cnt + 1'b1;
				// flag lands on the final stop bit cycle
				if (pos == stop_bit && cnt == CNT_W'(BIT_PERIOD - 2)) begin
					tx_end <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tx_buffer.sv ====
// transmit holding buffer
// one byte plus a full flag; checks load and send against the
// buffer state and dsr, flags violations on error and starts
// the transmitter through send_en
`timescale 1ns/1ps
`default_nettype none

module tx_buffer (
	input  logic                clock,
	input  logic                rst,
	input  link_pkg::link_ctl_t ctl,
	input  logic [7:0]          data_in,
	input  logic                dsr,
	input  logic                tx_end,
	output logic [7:0]          tx_byte,
	output logic                send_en,
	output logic                send_ok,
	output logic                error
);
	logic full;

	always_ff @(posedge clock) begin
		if (rst) begin
			full    <= 1'b0;
			send_en <= 1'b0;
			send_ok <= 1'b0;
			error   <= 1'b0;
		end else begin
			send_ok <= 1'b0;
			// frame finished, buffer free again
			if (tx_end) begin
				send_en <= 1'b0;
				full    <= 1'b0;
			end
			if (ctl.load) begin
				if (!full) begin
					full  <= 1'b1;
					error <= 1'b0;
				end else begin
					error <= 1'b1;
				end
			end
			if (ctl.send) begin
				if (!full || !dsr) begin
					// refused: the byte is dropped
					error <= 1'b1;
					full  <= 1'b0;
				end else begin
					error   <= 1'b0;
					send_en <= 1'b1;
					send_ok <= 1'b1;
				end
			end
		end
	end

	// a load on a full buffer keeps the old byte
	always_ff @(posedge clock) begin
		if (ctl.load && !full) begin
			tx_byte <= data_in;
		end
	end

endmodule

`default_nettype wire
